// ==== flist.f ====
+incdir+src
src/sample_pkg.sv
src/ctrl_pkg.sv
src/bank_if.sv
src/sync_fifo.sv
src/pingpong_bank_ram.sv
src/ingress_packer.sv
src/readout_scheduler.sv
src/egress_serializer.sv
src/symbol_buffer_top.sv
verification/symbol_buffer_checker.sv
verification/symbol_buffer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module symbol_buffer_tb -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0

// ==== src/bank_if.sv ====
`include "symbol_buffer_params.svh"

interface bank_if;

    localparam int ADDR_W = $clog2(`SB_PAIR_COUNT);

    // One pair word is written per odd input beat
    logic                   wr_en;
    logic                   wr_bank;
    logic [ADDR_W-1:0]      wr_addr;
    sample_pkg::pair_word_t wr_data;

    // Read data returns one cycle after rd_en
    logic                   rd_en;
    logic                   rd_bank;
    logic [ADDR_W-1:0]      rd_addr;
    sample_pkg::pair_word_t rd_data;

    modport writer (output wr_en, wr_bank, wr_addr, wr_data);
    modport reader (output rd_en, rd_bank, rd_addr, input rd_data);
    modport memory (input wr_en, wr_bank, wr_addr, wr_data, rd_en, rd_bank, rd_addr,
                    output rd_data);

endinterface

// ==== src/ctrl_pkg.sv ====
`include "symbol_buffer_params.svh"

package ctrl_pkg;

    typedef logic [`SB_TUSER_W-1:0] symbol_t;

    // One entry per full bank waiting for readout
    typedef struct packed {
        logic    bank;
        symbol_t symbol;
    } token_t;

    typedef enum int unsigned {
        STATUS_BUSY         = 0,
        STATUS_BACKPRESSURE = 1,
        STATUS_GAP          = 2
    } status_bit_e;

endpackage

// ==== src/egress_serializer.sv ====
`include "symbol_buffer_params.svh"

module egress_serializer (
    input  logic                   clk_axis,
    input  logic                   rst_axis_n,
    output logic                   sym_pop,
    input  ctrl_pkg::symbol_t      sym_data,
    input  logic                   sym_empty,
    output logic                   data_pop,
    input  sample_pkg::pair_word_t data_word,
    input  logic                   data_empty,
    output sample_pkg::beat_t      m_axis_tdata,
    output ctrl_pkg::symbol_t      m_axis_tuser,
    output logic                   m_axis_tvalid,
    output logic                   m_axis_tlast,
    input  logic                   m_axis_tready,
    output logic                   bins_left_nonzero,
    output logic [`SB_TUSER_W:0]   first_beat
);

    localparam int BIN_W = $clog2(`SB_NFFT + 1);

    logic [BIN_W-1:0]       bins_left;
    ctrl_pkg::symbol_t      cur_sym;
    sample_pkg::pair_word_t pair_q;
    logic                   pair_valid;
    logic                   second_q;
    logic                   sym_pending;
    logic                   data_pending;
    logic                   first_bin;
    logic                   emit;

    assign bins_left_nonzero = (bins_left != '0);
    assign sym_pop  = !bins_left_nonzero && !sym_empty && !sym_pending;
    assign data_pop = !pair_valid && !data_empty && !data_pending;

    // tready is looked at one cycle ahead of the beat it releases
    assign emit = pair_valid && bins_left_nonzero && m_axis_tready;

    always_ff @(posedge clk_axis) begin
        if (!rst_axis_n) begin
            bins_left     <= '0;
            pair_valid    <= 1'b0;
            second_q      <= 1'b0;
            sym_pending   <= 1'b0;
            data_pending  <= 1'b0;
            first_bin     <= 1'b0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            first_beat    <= '0;
        end else begin
            sym_pending   <= sym_pop;
            data_pending  <= data_pop;
            m_axis_tvalid <= emit;
            m_axis_tlast  <= emit && (bins_left == BIN_W'(1));
            first_beat    <= {emit && first_bin, cur_sym};
            if (sym_pending) begin
                cur_sym   <= sym_data;
                bins_left <= BIN_W'(`SB_NFFT);
                first_bin <= 1'b1;
            end
            if (data_pending) begin
                pair_q     <= data_word;
                pair_valid <= 1'b1;
                second_q   <= 1'b0;
            end
            if (emit) begin
                m_axis_tdata <= second_q ? pair_q.odd : pair_q.even;
                m_axis_tuser <= cur_sym;
                bins_left    <= bins_left - 1'b1;
                second_q     <= !second_q;
                first_bin    <= 1'b0;
                if (second_q) begin
                    pair_valid <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== src/ingress_packer.sv ====
`include "symbol_buffer_params.svh"

module ingress_packer (
    input  logic              clk_axis,
    input  logic              rst_axis_n,
    input  sample_pkg::beat_t s_axis_tdata,
    input  ctrl_pkg::symbol_t s_axis_tuser,
    input  logic              s_axis_tvalid,
    output logic              s_axis_tready,
    bank_if.writer            wr,
    output logic              token_push,
    output ctrl_pkg::token_t  token_data,
    input  logic              token_full,
    input  logic [1:0]        bank_release,
    output logic [1:0]        bank_held,
    output logic [1:0]        filled_bank
);

    localparam int ADDR_W = $clog2(`SB_PAIR_COUNT);
    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(`SB_PAIR_COUNT - 1);

    sample_pkg::beat_t beat_shifted;
    sample_pkg::beat_t even_q;
    logic [ADDR_W-1:0] pair_addr;
    logic              bank_sel;
    logic              odd_beat;
    logic              wait_bank;
    logic              wait_next;
    logic              token_pending;
    logic              accept;
    logic              last_pair;
    logic [1:0]        held_next;

    assign beat_shifted = sample_pkg::shift_beat(s_axis_tdata, `SB_INPUT_SHIFT);
    assign accept       = s_axis_tvalid && s_axis_tready;
    assign last_pair    = accept && odd_beat && (pair_addr == ADDR_LAST);

    // Pair word goes to memory on the odd beat itself
    assign wr.wr_en   = accept && odd_beat;
    assign wr.wr_bank = bank_sel;
    assign wr.wr_addr = pair_addr;
    assign wr.wr_data = {beat_shifted, even_q};

    assign token_push  = token_pending && !token_full;
    assign filled_bank = {token_push, token_data.bank};

    always_comb begin
        held_next = bank_held & ~bank_release;
        if (last_pair) begin
            held_next[bank_sel] = 1'b1;
        end
    end

    // Stall while the other bank is still waiting for readout
    assign wait_next = (wait_bank || last_pair) && held_next[!bank_sel];

    // ------------------------------------------------------------
    always_ff @(posedge clk_axis) begin
        if (!rst_axis_n) begin
            s_axis_tready <= 1'b0;
            pair_addr     <= '0;
            bank_sel      <= 1'b0;
            odd_beat      <= 1'b0;
            wait_bank     <= 1'b0;
            bank_held     <= 2'b00;
            token_pending <= 1'b0;
        end else begin
            s_axis_tready <= !wait_next;
            wait_bank     <= wait_next;
            bank_held     <= held_next;
            if ((wait_bank || last_pair) && !wait_next) begin
                bank_sel <= !bank_sel;
            end
            if (accept) begin
                odd_beat <= !odd_beat;
                if (odd_beat) begin
                    pair_addr <= (pair_addr == ADDR_LAST) ? '0 : pair_addr + 1'b1;
                end
            end
            if (last_pair) begin
                token_pending <= 1'b1;
            end else if (token_push) begin
                token_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_axis) begin
        if (accept && !odd_beat) begin
            even_q <= beat_shifted;
        end
        if (last_pair) begin
            token_data <= {bank_sel, s_axis_tuser};
        end
    end

endmodule

// ==== src/pingpong_bank_ram.sv ====
`include "symbol_buffer_params.svh"

module pingpong_bank_ram (
    input logic    clk_axis,
    bank_if.memory mem
);

    localparam int HALF_W = 2 * `SB_SAMPLE_W;

    // One antenna's two bins as {odd Q, odd I, even Q, even I}
    typedef logic [2*HALF_W-1:0] ant_pair_t;

    ant_pair_t ant0_mem [2][`SB_PAIR_COUNT];
    ant_pair_t ant1_mem [2][`SB_PAIR_COUNT];
    ant_pair_t rd_ant0;
    ant_pair_t rd_ant1;

    always_ff @(posedge clk_axis) begin
        if (mem.wr_en) begin
            ant0_mem[mem.wr_bank][mem.wr_addr] <= {mem.wr_data.odd.ant0_q, mem.wr_data.odd.ant0_i,
                                                   mem.wr_data.even.ant0_q,
                                                   mem.wr_data.even.ant0_i};
            ant1_mem[mem.wr_bank][mem.wr_addr] <= {mem.wr_data.odd.ant1_q, mem.wr_data.odd.ant1_i,
                                                   mem.wr_data.even.ant1_q,
                                                   mem.wr_data.even.ant1_i};
        end
        if (mem.rd_en) begin
            rd_ant0 <= ant0_mem[mem.rd_bank][mem.rd_addr];
            rd_ant1 <= ant1_mem[mem.rd_bank][mem.rd_addr];
        end
    end

    // Put the antenna halves back into beat order
    assign mem.rd_data = {rd_ant1[2*HALF_W-1:HALF_W], rd_ant0[2*HALF_W-1:HALF_W],
                          rd_ant1[HALF_W-1:0], rd_ant0[HALF_W-1:0]};

endmodule

// ==== src/readout_scheduler.sv ====
`include "symbol_buffer_params.svh"

module readout_scheduler (
    input  logic                                   clk_axis,
    input  logic                                   rst_axis_n,
    output logic                                   token_pop,
    input  ctrl_pkg::token_t                       token_data,
    input  logic                                   token_empty,
    bank_if.reader                                 rd,
    output logic                                   data_push,
    output sample_pkg::pair_word_t                 data_word,
    input  logic [$clog2(`SB_DATA_DEPTH + 1)-1:0]  data_free,
    output logic                                   sym_push,
    output ctrl_pkg::symbol_t                      sym_data,
    input  logic                                   sym_full,
    output logic [1:0]                             bank_release,
    output logic                                   gap_seen
);

    localparam int ADDR_W = $clog2(`SB_PAIR_COUNT);
    localparam int FREE_W = $clog2(`SB_DATA_DEPTH + 1);
    localparam int CD_W   = $clog2(`SB_GAP_CYCLES + 1);
    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(`SB_PAIR_COUNT - 1);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        READ
    } state_t;

    state_t            state;
    logic              bank_q;
    logic [ADDR_W-1:0] addr_q;
    logic [CD_W-1:0]   cooldown;
    logic              rd_last_q;
    logic              can_start;

    // Everything but the cooldown is ready for a new frame
    assign can_start = (state == IDLE) && !token_empty && !sym_full
                       && (data_free >= FREE_W'(`SB_PAIR_COUNT));
    assign token_pop = can_start && (cooldown == '0);
    assign gap_seen  = can_start && (cooldown != '0);

    assign sym_push = (state == LOAD);
    assign sym_data = token_data.symbol;

    assign rd.rd_en   = (state == READ);
    assign rd.rd_bank = bank_q;
    assign rd.rd_addr = addr_q;

    assign data_word = {sample_pkg::shift_beat(rd.rd_data.odd, `SB_OUTPUT_SHIFT),
                        sample_pkg::shift_beat(rd.rd_data.even, `SB_OUTPUT_SHIFT)};

    always_ff @(posedge clk_axis) begin
        if (!rst_axis_n) begin
            state        <= IDLE;
            bank_q       <= 1'b0;
            addr_q       <= '0;
            cooldown     <= '0;
            data_push    <= 1'b0;
            rd_last_q    <= 1'b0;
            bank_release <= 2'b00;
        end else begin
            data_push    <= rd.rd_en;
            rd_last_q    <= rd.rd_en && (addr_q == ADDR_LAST);
            bank_release <= rd_last_q ? (bank_q ? 2'b10 : 2'b01) : 2'b00;
            if (token_pop) begin
                cooldown <= CD_W'(`SB_GAP_CYCLES);
            end else if (cooldown != '0) begin
                cooldown <= cooldown - 1'b1;
            end
            case (state)
                IDLE: begin
                    if (token_pop) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    bank_q <= token_data.bank;
                    addr_q <= '0;
                    state  <= READ;
                end
                default: begin
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == ADDR_LAST) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/sample_pkg.sv ====
`include "symbol_buffer_params.svh"

package sample_pkg;

    typedef logic signed [`SB_SAMPLE_W-1:0] iq_t;

    // Fields from the top of the bus down to bit 0
    typedef struct packed {
        iq_t ant1_q;
        iq_t ant1_i;
        iq_t ant0_q;
        iq_t ant0_i;
    } beat_t;

    // Two successive beats with the even beat in the low half
    typedef struct packed {
        beat_t odd;
        beat_t even;
    } pair_word_t;

    function automatic beat_t shift_beat(beat_t b, int unsigned sh);
        beat_t r;
        r.ant0_i = b.ant0_i >>> sh;
        r.ant0_q = b.ant0_q >>> sh;
        r.ant1_i = b.ant1_i >>> sh;
        r.ant1_q = b.ant1_q >>> sh;
        return r;
    endfunction

endpackage

// ==== src/symbol_buffer_params.svh ====
`ifndef SYMBOL_BUFFER_PARAMS_SVH
`define SYMBOL_BUFFER_PARAMS_SVH

// Frame geometry
`define SB_NFFT          16
`define SB_PAIR_COUNT    (`SB_NFFT / 2)

// Sample and sideband widths
`define SB_SAMPLE_W      12
`define SB_TUSER_W       7

// Arithmetic right shifts at the input and at readout
`define SB_INPUT_SHIFT   1
`define SB_OUTPUT_SHIFT  1

// Minimum spacing between readout starts in clk_axis cycles
`define SB_GAP_CYCLES    40

// Queue depths
`define SB_TOKEN_DEPTH   2
`define SB_SYMBOL_DEPTH  4
`define SB_DATA_DEPTH    (2 * `SB_PAIR_COUNT)

`endif

// ==== src/symbol_buffer_top.sv ====
`include "symbol_buffer_params.svh"

module symbol_buffer_top (
    input  logic                      clk_axis,
    input  logic                      rst_axis_n,
    input  logic [4*`SB_SAMPLE_W-1:0] s_axis_tdata,
    input  logic [`SB_TUSER_W-1:0]    s_axis_tuser,
    input  logic                      s_axis_tvalid,
    input  logic                      s_axis_tlast,
    output logic                      s_axis_tready,
    output logic [4*`SB_SAMPLE_W-1:0] m_axis_tdata,
    output logic [`SB_TUSER_W-1:0]    m_axis_tuser,
    output logic                      m_axis_tvalid,
    output logic                      m_axis_tlast,
    input  logic                      m_axis_tready,
    output logic [2:0]                status_flags,
    output logic [15:0]               latency_debug
);

    logic                                  token_push;
    logic                                  token_pop;
    logic                                  token_full;
    logic                                  token_empty;
    ctrl_pkg::token_t                      token_in;
    ctrl_pkg::token_t                      token_out;
    logic                                  sym_push;
    logic                                  sym_pop;
    logic                                  sym_full;
    logic                                  sym_empty;
    ctrl_pkg::symbol_t                     sym_in;
    ctrl_pkg::symbol_t                     sym_out;
    logic                                  data_push;
    logic                                  data_pop;
    logic                                  data_empty;
    logic [$clog2(`SB_DATA_DEPTH + 1)-1:0] data_free;
    sample_pkg::pair_word_t                data_in;
    sample_pkg::pair_word_t                data_out;
    logic [1:0]                            bank_release;
    logic [1:0]                            bank_held;
    logic [1:0]                            filled_bank;
    logic                                  gap_seen;
    logic                                  bins_left_nonzero;
    logic [`SB_TUSER_W:0]                  first_beat;
    logic [15:0]                           lat_cnt [2];
    ctrl_pkg::symbol_t                     lat_sym [2];
    logic [1:0]                            lat_run;

    bank_if bank_bus ();

    ingress_packer ingress_packer_inst (
        .clk_axis, .rst_axis_n, .s_axis_tdata, .s_axis_tuser, .s_axis_tvalid, .s_axis_tready,
        .wr (bank_bus.writer), .token_push, .token_data (token_in), .token_full,
        .bank_release, .bank_held, .filled_bank
    );

    pingpong_bank_ram pingpong_bank_ram_inst (.clk_axis, .mem (bank_bus.memory));

    readout_scheduler readout_scheduler_inst (
        .clk_axis, .rst_axis_n, .token_pop, .token_data (token_out), .token_empty,
        .rd (bank_bus.reader), .data_push, .data_word (data_in), .data_free,
        .sym_push, .sym_data (sym_in), .sym_full, .bank_release, .gap_seen
    );

    egress_serializer egress_serializer_inst (
        .clk_axis, .rst_axis_n, .sym_pop, .sym_data (sym_out), .sym_empty,
        .data_pop, .data_word (data_out), .data_empty, .m_axis_tdata, .m_axis_tuser,
        .m_axis_tvalid, .m_axis_tlast, .m_axis_tready, .bins_left_nonzero, .first_beat
    );

    sync_fifo #(.DEPTH (`SB_TOKEN_DEPTH), .payload_t (ctrl_pkg::token_t)) token_fifo_inst (
        .clk_axis, .rst_axis_n, .push (token_push), .push_data (token_in), .pop (token_pop),
        .pop_data (token_out), .full (token_full), .empty (token_empty), .free_count ()
    );

    sync_fifo #(.DEPTH (`SB_SYMBOL_DEPTH), .payload_t (ctrl_pkg::symbol_t)) sym_fifo_inst (
        .clk_axis, .rst_axis_n, .push (sym_push), .push_data (sym_in), .pop (sym_pop),
        .pop_data (sym_out), .full (sym_full), .empty (sym_empty), .free_count ()
    );

    sync_fifo #(.DEPTH (`SB_DATA_DEPTH), .payload_t (sample_pkg::pair_word_t)) data_fifo_inst (
        .clk_axis, .rst_axis_n, .push (data_push), .push_data (data_in), .pop (data_pop),
        .pop_data (data_out), .full (), .empty (data_empty), .free_count (data_free)
    );

    // ------------------------------------------------------------
    // Per-bank latency from token push to first output beat
    always_ff @(posedge clk_axis) begin
        if (!rst_axis_n) begin
            lat_run       <= 2'b00;
            latency_debug <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (lat_run[b]) begin
                    lat_cnt[b] <= lat_cnt[b] + 16'd1;
                end
                if (first_beat[`SB_TUSER_W] && lat_run[b]
                    && (lat_sym[b] == first_beat[`SB_TUSER_W-1:0])) begin
                    latency_debug <= lat_cnt[b];
                    lat_run[b]    <= 1'b0;
                end
            end
            if (filled_bank[1]) begin
                lat_run[filled_bank[0]] <= 1'b1;
                lat_cnt[filled_bank[0]] <= '0;
                lat_sym[filled_bank[0]] <= token_in.symbol;
            end
        end
    end

    always_ff @(posedge clk_axis) begin
        if (!rst_axis_n) begin
            status_flags <= '0;
        end else begin
            status_flags[ctrl_pkg::STATUS_BUSY] <= (bank_held != 2'b00) || bins_left_nonzero;
            if (s_axis_tvalid && !s_axis_tready) begin
                status_flags[ctrl_pkg::STATUS_BACKPRESSURE] <= 1'b1;
            end
            if (gap_seen) begin
                status_flags[ctrl_pkg::STATUS_GAP] <= 1'b1;
            end
        end
    end

endmodule

// ==== src/sync_fifo.sv ====
module sync_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic                       clk_axis,
    input  logic                       rst_axis_n,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] free_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full       = (count == CNT_W'(DEPTH));
    assign empty      = (count == '0);
    assign free_count = CNT_W'(DEPTH) - count;

    always_ff @(posedge clk_axis) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_axis) begin
        if (!rst_axis_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

// ==== verification/symbol_buffer_checker.sv ====
`include "symbol_buffer_params.svh"

module symbol_buffer_checker #(
    parameter int TOTAL_BEATS = 192
) (
    input  logic                      clk_axis,
    input  logic                      rst_axis_n,
    input  logic [4*`SB_SAMPLE_W-1:0] s_axis_tdata,
    input  logic [`SB_TUSER_W-1:0]    s_axis_tuser,
    input  logic                      s_axis_tvalid,
    input  logic                      s_axis_tready,
    input  logic [4*`SB_SAMPLE_W-1:0] m_axis_tdata,
    input  logic [`SB_TUSER_W-1:0]    m_axis_tuser,
    input  logic                      m_axis_tvalid,
    input  logic                      m_axis_tlast,
    input  logic                      m_axis_tready,
    input  logic [2:0]                status_flags,
    input  logic [15:0]               latency_debug,
    input  logic                      report_req,
    output logic                      all_received,
    output logic                      report_done,
    output int                        error_count
);

    localparam int DATA_W = 4 * `SB_SAMPLE_W;
    localparam int SHIFT  = `SB_INPUT_SHIFT + `SB_OUTPUT_SHIFT;

    logic [DATA_W-1:0]      exp_data [$];
    logic [`SB_TUSER_W-1:0] exp_user [$];
    int                     errors [1:5];
    int                     out_count;
    logic                   reset_checked;
    logic                   bp_model;
    logic                   gap_prev;
    logic                   tready_prev;

    assign error_count = errors[1] + errors[2] + errors[3] + errors[4] + errors[5];

    // Each 12-bit field is shifted at the input and again at readout
    function automatic logic [DATA_W-1:0] scale_beat(logic [DATA_W-1:0] b);
        logic [DATA_W-1:0]             r;
        logic signed [`SB_SAMPLE_W-1:0] f;
        for (int i = 0; i < 4; i++) begin
            f = b[i*`SB_SAMPLE_W +: `SB_SAMPLE_W];
            r[i*`SB_SAMPLE_W +: `SB_SAMPLE_W] = f >>> SHIFT;
        end
        return r;
    endfunction

    function automatic string test_name(int n);
        case (n)
            1:       return "data integrity";
            2:       return "framing";
            3:       return "back-pressure without loss";
            4:       return "gap flag";
            default: return "reset and idle";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual, input int test_no);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errors[test_no]++;
        end
    endtask

    // ------------------------------------------------------------
    always @(posedge clk_axis) begin
        logic [DATA_W-1:0]      want;
        logic [`SB_TUSER_W-1:0] want_user;
        int                     passed;
        if (!rst_axis_n) begin
            reset_checked = 1'b0;
            bp_model      = 1'b0;
            gap_prev      = 1'b0;
            tready_prev   = 1'b0;
            out_count     = 0;
            for (int n = 1; n <= 5; n++) begin
                errors[n] = 0;
            end
            exp_data.delete();
            exp_user.delete();
            all_received <= 1'b0;
            report_done  <= 1'b0;
        end else begin
            if (!reset_checked) begin
                compare_value("s_axis_tready", 0, s_axis_tready, 5);
                compare_value("m_axis_tvalid", 0, m_axis_tvalid, 5);
                compare_value("m_axis_tlast", 0, m_axis_tlast, 5);
                compare_value("status_flags", 0, status_flags, 5);
                compare_value("latency_debug", 0, latency_debug, 5);
                reset_checked = 1'b1;
            end
            if (s_axis_tvalid && s_axis_tready) begin
                exp_data.push_back(scale_beat(s_axis_tdata));
                exp_user.push_back(s_axis_tuser);
            end
            // An output beat may only follow a cycle with m_axis_tready high
            if (m_axis_tvalid && !tready_prev) begin
                $display("output beat at %0t came without m_axis_tready in the cycle before",
                         $time);
                errors[3]++;
            end
            tready_prev = m_axis_tready;
            // Every cycle with tvalid high carries one beat
            if (m_axis_tvalid) begin
                if (exp_data.size() == 0) begin
                    $display("output beat at %0t has no matching input beat", $time);
                    errors[1]++;
                end else begin
                    want      = exp_data.pop_front();
                    want_user = exp_user.pop_front();
                    compare_value("m_axis_tdata", want, m_axis_tdata, 1);
                    compare_value("m_axis_tuser", want_user, m_axis_tuser, 2);
                end
                compare_value("m_axis_tlast", (out_count % `SB_NFFT) == `SB_NFFT - 1,
                              m_axis_tlast, 2);
                out_count++;
                if (out_count == TOTAL_BEATS) begin
                    all_received <= 1'b1;
                end
            end else if (m_axis_tlast) begin
                $display("m_axis_tlast high at %0t without m_axis_tvalid", $time);
                errors[2]++;
            end
            compare_value("status_flags backpressure", bp_model,
                          status_flags[ctrl_pkg::STATUS_BACKPRESSURE], 3);
            bp_model = bp_model | (s_axis_tvalid && !s_axis_tready);
            if (gap_prev && !status_flags[ctrl_pkg::STATUS_GAP]) begin
                $display("gap flag fell back to 0 at %0t", $time);
                errors[4]++;
            end
            gap_prev = status_flags[ctrl_pkg::STATUS_GAP];

            if (report_req && !report_done) begin
                if (out_count != TOTAL_BEATS || exp_data.size() != 0) begin
                    $display("beat count wrong: %0d beats received, %0d still expected",
                             out_count, exp_data.size());
                    errors[3]++;
                end
                if (!bp_model) begin
                    $display("s_axis_tready never went low while s_axis_tvalid was high");
                    errors[3]++;
                end
                if (!status_flags[ctrl_pkg::STATUS_GAP]) begin
                    $display("gap flag was never set although frames came fast");
                    errors[4]++;
                end
                if (status_flags[ctrl_pkg::STATUS_BUSY]) begin
                    $display("busy flag still set after the last beat drained");
                    errors[5]++;
                end
                if (latency_debug == 16'd0) begin
                    $display("latency_debug is still zero after the first frame");
                    errors[5]++;
                end
                passed = 0;
                for (int n = 1; n <= 5; n++) begin
                    $display("test %0d %s: %s, %0d errors", n, test_name(n),
                             (errors[n] == 0) ? "pass" : "fail", errors[n]);
                    if (errors[n] == 0) begin
                        passed++;
                    end
                end
                $display("summary: %0d of 5 tests passed, %0d failed, %0d errors in total",
                         passed, 5 - passed, error_count);
                report_done <= 1'b1;
            end
        end
    end

endmodule

// ==== verification/symbol_buffer_tb.sv ====
`include "symbol_buffer_params.svh"

module symbol_buffer_tb;

    localparam int SYMBOLS     = 12;
    localparam int TOTAL_BEATS = SYMBOLS * `SB_NFFT;
    localparam int MAX_CYCLES  = SYMBOLS * 400;
    localparam int DRAIN_LIMIT = 16;

    logic                      clk_axis;
    logic                      rst_axis_n;
    logic [4*`SB_SAMPLE_W-1:0] s_axis_tdata;
    logic [`SB_TUSER_W-1:0]    s_axis_tuser;
    logic                      s_axis_tvalid;
    logic                      s_axis_tlast;
    logic                      s_axis_tready;
    logic [4*`SB_SAMPLE_W-1:0] m_axis_tdata;
    logic [`SB_TUSER_W-1:0]    m_axis_tuser;
    logic                      m_axis_tvalid;
    logic                      m_axis_tlast;
    logic                      m_axis_tready;
    logic [2:0]                status_flags;
    logic [15:0]               latency_debug;
    logic                      all_received;
    logic                      report_req;
    logic                      report_done;
    int                        error_count;
    logic [31:0]               rng_state;
    int                        sent;
    int                        drain;
    int                        cycles = 0;

    symbol_buffer_top symbol_buffer_top_inst (
        .clk_axis, .rst_axis_n, .s_axis_tdata, .s_axis_tuser, .s_axis_tvalid, .s_axis_tlast,
        .s_axis_tready, .m_axis_tdata, .m_axis_tuser, .m_axis_tvalid, .m_axis_tlast,
        .m_axis_tready, .status_flags, .latency_debug
    );

    symbol_buffer_checker #(.TOTAL_BEATS (TOTAL_BEATS)) checker_inst (
        .clk_axis, .rst_axis_n, .s_axis_tdata, .s_axis_tuser, .s_axis_tvalid, .s_axis_tready,
        .m_axis_tdata, .m_axis_tuser, .m_axis_tvalid, .m_axis_tlast, .m_axis_tready,
        .status_flags, .latency_debug, .report_req, .all_received, .report_done, .error_count
    );

    initial begin
        clk_axis = 1'b0;
        forever #20 clk_axis = ~clk_axis;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // tvalid stays up until the beat is taken
    task automatic drive_inputs();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic        accepted;
        accepted = s_axis_tvalid && s_axis_tready;
        if (accepted) begin
            sent++;
        end
        if (sent == TOTAL_BEATS) begin
            s_axis_tvalid <= 1'b0;
            s_axis_tlast  <= 1'b0;
        end else if (!s_axis_tvalid || accepted) begin
            if (next_random() % 4 == 0) begin
                s_axis_tvalid <= 1'b0;
            end else begin
                r_hi = next_random();
                r_lo = next_random();
                s_axis_tvalid <= 1'b1;
                s_axis_tdata  <= {r_hi[15:0], r_lo};
                s_axis_tuser  <= `SB_TUSER_W'(sent / `SB_NFFT + 1);
                s_axis_tlast  <= (sent % `SB_NFFT) == `SB_NFFT - 1;
            end
        end
        m_axis_tready <= (next_random() % 10) >= 3;
    endtask

    // ------------------------------------------------------------
    always @(posedge clk_axis) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rst_axis_n    = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tuser  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        report_req    = 1'b0;
        rng_state     = 32'ha69db9b4;
        sent          = 0;
        repeat (3) @(posedge clk_axis);
        rst_axis_n <= 1'b1;
        while (!all_received) begin
            @(posedge clk_axis);
            drive_inputs();
        end
        drain = 0;
        while (status_flags[ctrl_pkg::STATUS_BUSY] && drain < DRAIN_LIMIT) begin
            @(posedge clk_axis);
            drain++;
        end
        report_req <= 1'b1;
        while (!report_done) begin
            @(posedge clk_axis);
        end
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
